// File: flist.f
verilog/pongPkg.sv
verilog/gameControl.sv
verilog/paddleMapper.sv
verilog/ballMotion.sv
verilog/paddleCollision.sv
verilog/scoreKeeper.sv
verilog/ssdScan.sv
verilog/pongTop.sv
verif/pongTop_properties.sv
verif/pongTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module pongTb -f flist.f -o pongSim \
	&& ./obj_dir/pongSim \
	|| exit 1

// File: verif/pongInput.txt
// leftPot rightPot expectedLeftRow expectedRightRow, all hex
// Row is 0 below the deadzone, else 2*pot - 41 clamped to 430
00 00 000 000
14 FF 000 1AE
15 EC 001 1AE
64 EB 09F 1AD
80 C8 0D7 167
40 32 057 03B
EB 15 1AD 001
EC 14 1AE 000
FF 80 1AE 0D7
C8 64 167 09F
32 40 03B 057
80 FF 0D7 1AE

// File: verif/pongTb.sv
`timescale 1ns/1ps

module pongTb;

	localparam int rowCount = 12;
	localparam int colCount = 4;	// leftPot, rightPot, left row, right row
	localparam int waitLimit = 40;	// Short waits, in cycles
	localparam int gameLimit = 30000;	// Whole game to nine points

	logic DIV_CLK;
	logic reset;
	logic start;
	logic [7:0] leftPot;
	logic [7:0] rightPot;
	pongPkg::ballPos_t ballPos;
	pongPkg::yCoord_t leftPaddleY;
	pongPkg::yCoord_t rightPaddleY;
	pongPkg::ssdOut_t ssd;

	logic [15:0] rows [rowCount*colCount];	// Flat, colCount words per row
	logic monitorOn;
	int refLeft;	// Expected scores
	int refRight;
	int refSpeed;	// Expected pixels per ball step
	int lastDx;	// Sign gives last horizontal direction
	pongPkg::ballPos_t prevPos;

	pongTop dut(.*);

	always #50 DIV_CLK = ~DIV_CLK;	// 100 ns period

	////////////////////////////////////////////////////////////
	// Helpers
	task automatic failNow(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic checkValue(input string name, input int got, input int expected);
		assert (got == expected)
		else failNow($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected));
	endtask

	// Segments a..g, MSB is a, low means lit
	function automatic logic [6:0] segments(input int value);
		case (value)
			0: return 7'h01;
			1: return 7'h4F;
			2: return 7'h12;
			3: return 7'h06;
			4: return 7'h4C;
			5: return 7'h24;
			6: return 7'h20;
			7: return 7'h0F;
			8: return 7'h00;
			9: return 7'h04;
			default: return 7'h7F;	// Dark
		endcase
	endfunction

	function automatic int selectedDigit();
		for (int i = 0; i < 4; i++)
			if (ssd.anodes == ~(4'b0001 << i))
				return i;
		return -1;	// None or several
	endfunction

	function automatic logic atServe(input pongPkg::ballPos_t pos);
		return (pos.x == pongPkg::serveX) && (pos.y == pongPkg::serveY);
	endfunction

	function automatic logic atPark(input pongPkg::ballPos_t pos);
		return (pos.x == pongPkg::parkX) && (pos.y == pongPkg::parkY);
	endfunction

	// Waits for one digit on the scan, then checks its segments
	task automatic checkDigit(input int idx, input int value);
		int cycles;
		cycles = 0;
		@(negedge DIV_CLK);
		while (selectedDigit() != idx)
		begin
			assert (cycles < waitLimit)
			else failNow($sformatf("Display never selected digit %0d", idx));
			@(negedge DIV_CLK);
			cycles++;
		end
		checkValue($sformatf("ssd.cathodes digit %0d", idx), int'(ssd.cathodes),
			int'(segments(value)));
	endtask

	////////////////////////////////////////////////////////////
	// Per cycle reference of ball motion and scores
	task automatic checkCycle();
		int dx;
		int dy;
		int stepSize;
		int digit;
		int shown;
		dx = int'(ballPos.x) - int'(prevPos.x);
		dy = int'(ballPos.y) - int'(prevPos.y);
		stepSize = (dx < 0) ? -dx : dx;
		if (ballPos != prevPos)
		begin
			if (atServe(ballPos) && atPark(prevPos))	// New game
			begin
				refLeft = 0;
				refRight = 0;
				refSpeed = pongPkg::startSpeed;
			end
			else if (atServe(ballPos))	// Goal scored
			begin
				if (lastDx < 0)
					refRight++;	// Into the left goal
				else
					refLeft++;
				refSpeed = pongPkg::serveSpeed;
			end
			else if (atPark(ballPos))
			begin
				assert (refLeft == pongPkg::winScore || refRight == pongPkg::winScore)
				else failNow("Ball parked before a player reached the winning score");
			end
			else
			begin
				assert (dx == dy || dx == -dy)
				else failNow("Ball moved by different amounts on x and y");
				if (stepSize == refSpeed + 1)
					refSpeed++;	// Paddle hit speeds up
				checkValue("ballPos step", stepSize, refSpeed);
				lastDx = dx;
			end
			prevPos = ballPos;
		end
		digit = selectedDigit();
		assert (digit >= 0)
		else failNow("Display does not select exactly one digit");
		shown = (digit == 0) ? refRight : ((digit == 2) ? refLeft : 0);
		checkValue($sformatf("ssd.cathodes digit %0d", digit), int'(ssd.cathodes),
			int'(segments(shown)));
	endtask

	always @(negedge DIV_CLK)
	begin
		if (monitorOn)
			checkCycle();
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	task automatic startGame();
		int cycles;
		cycles = 0;
		@(posedge DIV_CLK);
		#1 start = 1'b1;
		@(negedge DIV_CLK);
		while (!atServe(ballPos))
		begin
			assert (cycles < waitLimit)
			else failNow("Ball never reached the serve point after start");
			@(negedge DIV_CLK);
			cycles++;
		end
		@(posedge DIV_CLK);
		#1 start = 1'b0;
	endtask

	task automatic applyRow(input int r);
		int cycles;
		pongPkg::yCoord_t wantLeft;
		pongPkg::yCoord_t wantRight;
		wantLeft = pongPkg::yCoord_t'(rows[r*colCount+2]);
		wantRight = pongPkg::yCoord_t'(rows[r*colCount+3]);
		cycles = 0;
		@(posedge DIV_CLK);
		#1;
		leftPot = rows[r*colCount][7:0];
		rightPot = rows[r*colCount+1][7:0];
		@(negedge DIV_CLK);
		while (leftPaddleY != wantLeft || rightPaddleY != wantRight)
		begin
			assert (cycles < waitLimit)
			else failNow($sformatf("Paddles did not reach the rows of data row %0d", r));
			@(negedge DIV_CLK);
			cycles++;
		end
		repeat (3 * pongPkg::paddleUpdates)	// Must hold while pots hold
		begin
			@(negedge DIV_CLK);
			checkValue("leftPaddleY", int'(leftPaddleY), int'(wantLeft));
			checkValue("rightPaddleY", int'(rightPaddleY), int'(wantRight));
		end
	endtask

	initial
	begin
		int cycles;
		int lastRow;
		DIV_CLK = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		leftPot = '0;
		rightPot = '0;
		monitorOn = 1'b0;
		refLeft = 0;
		refRight = 0;
		refSpeed = pongPkg::startSpeed;
		lastDx = 0;
		cycles = 0;
		lastRow = (rowCount - 1) * colCount;
		$readmemh("verif/pongInput.txt", rows);
		repeat (5) @(posedge DIV_CLK);
		#1 reset = 1'b0;

		// Parked, paddles at top, zero scores
		@(negedge DIV_CLK);
		checkValue("ballPos.x", int'(ballPos.x), int'(pongPkg::parkX));
		checkValue("ballPos.y", int'(ballPos.y), int'(pongPkg::parkY));
		checkValue("leftPaddleY", int'(leftPaddleY), 0);
		checkValue("rightPaddleY", int'(rightPaddleY), 0);
		checkDigit(0, 0);
		checkDigit(2, 0);

		@(posedge DIV_CLK);
		#1;
		prevPos = ballPos;
		monitorOn = 1'b1;
		startGame();
		for (int r = 0; r < rowCount; r++)
			applyRow(r);

		// Last row leaves the right paddle low, so the left player wins
		@(negedge DIV_CLK);
		while (!atPark(ballPos))
		begin
			assert (cycles < gameLimit)
			else failNow("Game did not end within the cycle limit");
			@(negedge DIV_CLK);
			cycles++;
		end

		// Pots move while parked, paddles stay put
		@(posedge DIV_CLK);
		#1;
		leftPot = rows[0][7:0];
		rightPot = rows[1][7:0];
		repeat (4 * pongPkg::paddleUpdates)
		begin
			@(negedge DIV_CLK);
			checkValue("leftPaddleY", int'(leftPaddleY), int'(rows[lastRow+2]));
			checkValue("rightPaddleY", int'(rightPaddleY), int'(rows[lastRow+3]));
		end

		startGame();	// Second game clears both scores
		checkDigit(0, 0);
		checkDigit(2, 0);
		$display("Test passed");
		$finish;
	end

endmodule

// File: verif/pongTop_properties.sv
`timescale 1ns/1ps

module pongTop_properties
(
	input logic DIV_CLK,
	input logic reset,
	input logic start,
	input pongPkg::ballPos_t ballPos,
	input pongPkg::ssdOut_t ssd
);

	logic parked;
	logic awaitStart;	// High from reset until the first start

	assign parked = (ballPos.x == pongPkg::parkX) && (ballPos.y == pongPkg::parkY);

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			awaitStart <= 1'b1;
		else if (start)
			awaitStart <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	oneAnode: assert property (@(posedge DIV_CLK) disable iff (reset) $onehot(~ssd.anodes))
		else $error("Display drives more or less than one anode low");

	ballOnField: assert property (@(posedge DIV_CLK) disable iff (reset)
		!parked |-> (ballPos.y < pongPkg::yCoord_t'(pongPkg::fieldHeight)))
		else $error("Ball left the field vertically");	// Wrap on underflow lands here

	parkedAfterReset: assert property (@(posedge DIV_CLK) disable iff (reset)
		awaitStart |-> parked)
		else $error("Ball left the park position before start");

endmodule

bind pongTop pongTop_properties uProps
(
	.DIV_CLK(DIV_CLK),
	.reset(reset),
	.start(start),
	.ballPos(ballPos),
	.ssd(ssd)
);

// File: verilog/ballMotion.sv
`timescale 1ns/1ps

module ballMotion
(
	input logic DIV_CLK,
	input logic reset,
	input pongPkg::gameCmd_t cmd,
	input pongPkg::ballEvents_t hits,	// Only the paddle hits are used
	output pongPkg::ballPos_t ballPos,
	output logic goalLeft,
	output logic goalRight
);

	logic [pongPkg::speedBits-1:0] speed;	// Same on both axes
	logic dirRight;
	logic dirDown;	// Y grows downward
	logic parkBall;
	logic serve;
	logic paddleHit;
	pongPkg::xCoord_t stepX;
	pongPkg::yCoord_t stepY;

	assign parkBall = cmd.serveLeft && cmd.serveRight;
	assign serve = cmd.serveLeft ^ cmd.serveRight;	// Exactly one side named
	assign paddleHit = hits.hitLeftPaddle || hits.hitRightPaddle;
	assign stepX = pongPkg::xCoord_t'(speed);
	assign stepY = pongPkg::yCoord_t'(speed);

	////////////////////////////////////////////////////////////
	// Position
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			ballPos.x <= pongPkg::parkX;
			ballPos.y <= pongPkg::parkY;
		end
		else if (parkBall)
		begin
			ballPos.x <= pongPkg::parkX;	// Game over
			ballPos.y <= pongPkg::parkY;
		end
		else if (cmd.newGame || serve)
		begin
			ballPos.x <= pongPkg::serveX;	// Center of field
			ballPos.y <= pongPkg::serveY;
		end
		else if (cmd.ballStep)
		begin
			ballPos.x <= dirRight ? ballPos.x + stepX : ballPos.x - stepX;
			ballPos.y <= dirDown ? ballPos.y + stepY : ballPos.y - stepY;
		end
	end

	// Direction and speed
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			speed <= pongPkg::speedBits'(pongPkg::startSpeed);
			dirRight <= 1'b1;
			dirDown <= 1'b0;
		end
		else if (cmd.newGame)
		begin
			speed <= pongPkg::speedBits'(pongPkg::startSpeed);
			dirRight <= 1'b1;	// Right and up
			dirDown <= 1'b0;
		end
		else if (serve)
		begin
			speed <= pongPkg::speedBits'(pongPkg::serveSpeed);
			dirRight <= cmd.serveRight;
			dirDown <= 1'b0;
		end
		else if (cmd.bounceCheck)
		begin
			if (ballPos.y < pongPkg::topLimit + stepY)	// Top wall
				dirDown <= 1'b1;
			else if (ballPos.y >= pongPkg::bottomLimit)
				dirDown <= 1'b0;
			if (hits.hitLeftPaddle)
				dirRight <= 1'b1;
			else if (hits.hitRightPaddle)
				dirRight <= 1'b0;
			if (paddleHit)
				speed <= speed + pongPkg::speedBits'(1);	// Rally speeds up
		end
	end

	// Goal flags; also high while parked, only sampled in sCheck
	assign goalLeft = (ballPos.x < stepX);
	assign goalRight = (ballPos.x >= pongPkg::goalRightX);

endmodule

// File: verilog/gameControl.sv
`timescale 1ns/1ps

module gameControl
(
	input logic DIV_CLK,
	input logic reset,
	input logic start,
	input pongPkg::ballEvents_t events,
	input logic gameWon,	// From score counters
	output pongPkg::gameCmd_t cmd
);

	localparam int passBits = $clog2(pongPkg::paddleUpdates);

	pongPkg::gameState_t state;
	pongPkg::gameState_t nextState;
	logic [passBits-1:0] paddlePass;	// sPaddles passes so far
	logic lastPass;
	logic parkBall;

	assign lastPass = (paddlePass == passBits'(pongPkg::paddleUpdates - 1));
	assign parkBall = (state == pongPkg::sWait) && gameWon;	// Game over, clear the field

	////////////////////////////////////////////////////////////
	// State register and pass counter
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state <= pongPkg::sIdle;
			paddlePass <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == pongPkg::sPaddles)
				paddlePass <= lastPass ? '0 : paddlePass + passBits'(1);
		end
	end

	// Next state
	always_comb
	begin
		nextState = state;	// Hold by default
		case (state)
			pongPkg::sIdle:
				nextState = pongPkg::sMenu;
			pongPkg::sMenu:
				if (start)
					nextState = pongPkg::sSetup;
			pongPkg::sSetup:
				nextState = pongPkg::sWait;
			pongPkg::sWait:
				nextState = gameWon ? pongPkg::sIdle : pongPkg::sPaddles;
			pongPkg::sPaddles:
				if (lastPass)
					nextState = pongPkg::sBall;
			pongPkg::sBall:
				nextState = pongPkg::sCheck;
			pongPkg::sCheck:
			begin
				if (events.goalLeft)	// Into left goal, point for right
					nextState = pongPkg::sScoreRight;
				else if (events.goalRight)
					nextState = pongPkg::sScoreLeft;
				else
					nextState = pongPkg::sPaddles;
			end
			pongPkg::sScoreLeft, pongPkg::sScoreRight:
				nextState = pongPkg::sWait;
			default:
				nextState = pongPkg::sIdle;
		endcase
	end

	// Strobes decoded straight from state
	assign cmd.newGame = (state == pongPkg::sSetup);
	assign cmd.serveLeft = (state == pongPkg::sScoreRight) || parkBall;	// Loser serves
	assign cmd.serveRight = (state == pongPkg::sScoreLeft) || parkBall;
	assign cmd.paddleStep = (state == pongPkg::sPaddles);
	assign cmd.ballStep = (state == pongPkg::sBall);
	assign cmd.bounceCheck = (state == pongPkg::sCheck);

endmodule

// File: verilog/paddleCollision.sv
`timescale 1ns/1ps

module paddleCollision
(
	input pongPkg::ballPos_t ballPos,
	input pongPkg::yCoord_t leftPaddleY,
	input pongPkg::yCoord_t rightPaddleY,
	output logic hitLeftPaddle,
	output logic hitRightPaddle
);

	pongPkg::xCoord_t rightEdgeX;
	pongPkg::yCoord_t centerY;

	// Probe points on the ball edges
	assign rightEdgeX = ballPos.x + pongPkg::xCoord_t'(pongPkg::ballSize);
	assign centerY = ballPos.y + pongPkg::yCoord_t'(pongPkg::ballSize / 2);

	// Half-open rectangle test
	function automatic logic inPaddle
	(
		input pongPkg::xCoord_t pointX,
		input pongPkg::yCoord_t pointY,
		input pongPkg::xCoord_t padX,
		input pongPkg::yCoord_t padY
	);
		return (pointX >= padX)
			&& (pointX < padX + pongPkg::xCoord_t'(pongPkg::paddleWidth))
			&& (pointY >= padY)
			&& (pointY < padY + pongPkg::yCoord_t'(pongPkg::paddleHeight));
	endfunction

	assign hitLeftPaddle = inPaddle(ballPos.x, centerY, pongPkg::leftPaddleX, leftPaddleY);
	assign hitRightPaddle = inPaddle(rightEdgeX, centerY, pongPkg::rightPaddleX, rightPaddleY);

endmodule

// File: verilog/paddleMapper.sv
`timescale 1ns/1ps

module paddleMapper
(
	input logic DIV_CLK,
	input logic reset,
	input logic paddleStep,
	input logic [7:0] pot,	// Raw pot reading
	input logic newGame,
	output pongPkg::yCoord_t paddleY
);

	logic [8:0] scaledPot;
	logic [8:0] liftedPot;
	pongPkg::yCoord_t mappedY;

	assign scaledPot = {pot, 1'b0};	// Double, 0 to 510
	assign liftedPot = scaledPot - 9'(pongPkg::potDeadzone);

	// Deadzone at the low end, clamp at the bottom of the field
	always_comb
	begin
		if (scaledPot < 9'(pongPkg::potDeadzone))
			mappedY = '0;
		else if (liftedPot > 9'(pongPkg::paddleMaxY))
			mappedY = pongPkg::paddleMaxY;
		else
			mappedY = {1'b0, liftedPot};
	end

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			paddleY <= '0;
		else if (newGame)
			paddleY <= '0;	// Paddles start at the top
		else if (paddleStep)
			paddleY <= mappedY;
	end

endmodule

// File: verilog/pongPkg.sv
package pongPkg;

	// Coordinate and score types
	typedef logic [10:0] xCoord_t;	// Horizontal position, 0 to 641
	typedef logic [9:0] yCoord_t;	// Vertical position, 0 to 481
	typedef logic [3:0] score_t;	// One decimal digit per player

	////////////////////////////////////////////////////////////
	// Field geometry
	localparam int fieldWidth = 640;
	localparam int fieldHeight = 480;
	localparam xCoord_t parkX = xCoord_t'(fieldWidth + 1);	// Just off screen
	localparam yCoord_t parkY = yCoord_t'(fieldHeight + 1);
	localparam int ballSize = 10;	// Square ball
	localparam xCoord_t serveX = xCoord_t'(fieldWidth / 2 - ballSize / 2);	// 315
	localparam yCoord_t serveY = yCoord_t'(fieldHeight / 2 - ballSize / 2);	// 235
	localparam yCoord_t topLimit = '0;	// Top bounce offset, added to speed
	localparam yCoord_t bottomLimit = yCoord_t'(fieldHeight - ballSize);	// 470
	localparam xCoord_t goalRightX = xCoord_t'(fieldWidth - ballSize);	// 630

	// Paddle geometry
	localparam xCoord_t leftPaddleX = 11'd40;
	localparam xCoord_t rightPaddleX = 11'd600;
	localparam int paddleWidth = 10;
	localparam int paddleHeight = 50;

	// Pot to paddle mapping
	localparam int potDeadzone = 41;
	localparam yCoord_t paddleMaxY = 10'd430;	// Keeps paddle fully on the field

	// Ball speed, pixels per step on both axes
	localparam int startSpeed = 2;
	localparam int serveSpeed = 1;	// Slow serve after a goal
	localparam int speedBits = 7;

	// Sequencing
	localparam int paddleUpdates = 4;	// Paddle passes per ball step
	localparam int winScore = 9;
	localparam int scanBits = 4;	// Display scan counter width

	////////////////////////////////////////////////////////////
	typedef struct packed
	{
		xCoord_t x;	// Top left corner
		yCoord_t y;
	} ballPos_t;

	// One-cycle strobes; both serve strobes together park the ball
	typedef struct packed
	{
		logic newGame;
		logic serveLeft;	// Serve toward the left player
		logic serveRight;
		logic paddleStep;
		logic ballStep;
		logic bounceCheck;
	} gameCmd_t;

	typedef struct packed
	{
		logic goalLeft;	// Ball entered the left goal
		logic goalRight;
		logic hitLeftPaddle;
		logic hitRightPaddle;
	} ballEvents_t;

	typedef struct packed
	{
		logic [3:0] anodes;	// Active low
		logic [6:0] cathodes;	// Segments a to g, active low
	} ssdOut_t;

	typedef enum logic [3:0]
	{
		sIdle = 4'd0,
		sMenu = 4'd1,
		sSetup = 4'd2,
		sWait = 4'd3,
		sPaddles = 4'd4,
		sBall = 4'd5,
		sCheck = 4'd6,
		sScoreLeft = 4'd7,	// Left player scored
		sScoreRight = 4'd8
	} gameState_t;

endpackage

// File: verilog/pongTop.sv
`timescale 1ns/1ps

module pongTop
(
	input logic DIV_CLK,
	input logic reset,
	input logic start,	// Start button, level
	input logic [7:0] leftPot,
	input logic [7:0] rightPot,
	output pongPkg::ballPos_t ballPos,
	output pongPkg::yCoord_t leftPaddleY,
	output pongPkg::yCoord_t rightPaddleY,
	output pongPkg::ssdOut_t ssd
);

	pongPkg::gameCmd_t cmd;	// Strobes from the sequencer
	wire pongPkg::ballEvents_t events;	// Goals from ball, hits from collision
	pongPkg::score_t leftScore;
	pongPkg::score_t rightScore;
	logic gameWon;

	////////////////////////////////////////////////////////////
	// Control
	gameControl uControl
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.start(start),
		.events(events),
		.gameWon(gameWon),
		.cmd(cmd)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	paddleMapper uLeftPaddle
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.paddleStep(cmd.paddleStep),
		.pot(leftPot),
		.newGame(cmd.newGame),
		.paddleY(leftPaddleY)
	);

	paddleMapper uRightPaddle
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.paddleStep(cmd.paddleStep),
		.pot(rightPot),
		.newGame(cmd.newGame),
		.paddleY(rightPaddleY)
	);

	ballMotion uBall
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.cmd(cmd),
		.hits(events),
		.ballPos(ballPos),
		.goalLeft(events.goalLeft),
		.goalRight(events.goalRight)
	);

	paddleCollision uCollision
	(
		.ballPos(ballPos),
		.leftPaddleY(leftPaddleY),
		.rightPaddleY(rightPaddleY),
		.hitLeftPaddle(events.hitLeftPaddle),
		.hitRightPaddle(events.hitRightPaddle)
	);

	scoreKeeper uScore
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.cmd(cmd),
		.leftScore(leftScore),
		.rightScore(rightScore),
		.gameWon(gameWon)
	);

	ssdScan uDisplay
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.leftScore(leftScore),
		.rightScore(rightScore),
		.ssd(ssd)
	);

endmodule

// File: verilog/scoreKeeper.sv
`timescale 1ns/1ps

module scoreKeeper
(
	input logic DIV_CLK,
	input logic reset,
	input pongPkg::gameCmd_t cmd,
	output pongPkg::score_t leftScore,
	output pongPkg::score_t rightScore,
	output logic gameWon
);

	// Serve goes to the side that lost the point; park pair counts nothing
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			leftScore <= '0;
			rightScore <= '0;
		end
		else if (cmd.newGame)
		begin
			leftScore <= '0;	// Fresh game
			rightScore <= '0;
		end
		else if (cmd.serveRight && !cmd.serveLeft)
			leftScore <= leftScore + pongPkg::score_t'(1);
		else if (cmd.serveLeft && !cmd.serveRight)
			rightScore <= rightScore + pongPkg::score_t'(1);
	end

	assign gameWon = (leftScore == pongPkg::score_t'(pongPkg::winScore))
		|| (rightScore == pongPkg::score_t'(pongPkg::winScore));

endmodule

// File: verilog/ssdScan.sv
`timescale 1ns/1ps

module ssdScan
(
	input logic DIV_CLK,
	input logic reset,
	input pongPkg::score_t leftScore,
	input pongPkg::score_t rightScore,
	output pongPkg::ssdOut_t ssd
);

	logic [pongPkg::scanBits-1:0] scanCount;	// Free running
	logic [1:0] digitSel;
	pongPkg::score_t digit;
	logic [3:0] anodes;
	logic [6:0] cathodes;

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			scanCount <= '0;
		else
			scanCount <= scanCount + pongPkg::scanBits'(1);
	end

	assign digitSel = scanCount[pongPkg::scanBits-1 -: 2];	// Top two bits

	// Digit mux, 0 rightmost
	always_comb
	begin
		case (digitSel)
			2'd0: digit = rightScore;
			2'd2: digit = leftScore;
			default: digit = '0;	// Spacer digits show zero
		endcase
	end

	assign anodes = ~(4'b0001 << digitSel);	// One anode low

	// Segment decode, order a to g
	always_comb
	begin
		case (digit)
			4'd0: cathodes = 7'b0000001;
			4'd1: cathodes = 7'b1001111;
			4'd2: cathodes = 7'b0010010;
			4'd3: cathodes = 7'b0000110;
			4'd4: cathodes = 7'b1001100;
			4'd5: cathodes = 7'b0100100;
			4'd6: cathodes = 7'b0100000;
			4'd7: cathodes = 7'b0001111;
			4'd8: cathodes = 7'b0000000;
			4'd9: cathodes = 7'b0000100;
			default: cathodes = 7'b1111111;	// Blank above 9
		endcase
	end

	assign ssd = '{anodes: anodes, cathodes: cathodes};

endmodule
